// File: hw/dab_pkg.sv
package dab_pkg;

  ////////////////////////////////////////
  // converter-side codes
  ////////////////////////////////////////

  // raw adc words from the voltage sense chain
  typedef logic signed [13:0] in_code_t;    // vdc1 / vdc2 code

  // switching frequency word from the host
  typedef logic signed [18:0] fs_code_t;    // fs code

  // angle code, 255 stands for pi
  typedef logic signed [8:0]  out_code_t;   // tau1 / tau2 / phi

  localparam int FULL_SCALE = 255;          // pi in out_code_t units

  ////////////////////////////////////////
  // modulation mode reported with results
  ////////////////////////////////////////

  // 0 and 2 belong to the square-root branches, not built here
  typedef enum logic [1:0] {
    MODE_SINGLE = 2'd1,                     // single-side branch (2b)
    MODE_NONE   = 2'd3                      // nothing valid, outputs held
  } mode_e;

endpackage

// File: hw/arith_pkg.sv
package arith_pkg;

  ////////////////////////////////////////
  // integer datapath for the tau2 division
  ////////////////////////////////////////

  // numerator magnitude width, also the divider step count
  localparam int NUM_W = 24;

  typedef logic signed [NUM_W:0] num_t;     // 255*den*vdc1 - gain*fs
  typedef logic [17:0]           den_t;     // turns_num * vdc2, unsigned
  typedef logic [NUM_W-1:0]      quo_t;     // floored quotient

  // divider result, bad passes through with zero quotient
  typedef struct packed {
    quo_t quo;                              // tau2 in out code units
    logic bad;                              // request was not divided
  } quo_rsp_t;

endpackage

// File: hw/div_req_if.sv
`timescale 1ns/1ps

// one division request, valid/ready transfer
interface div_req_if;
  import arith_pkg::*;

  logic valid;                              // request pending
  logic ready;                              // divider idle
  num_t num;                                // signed numerator
  den_t den;                                // unsigned denominator
  logic bad;                                // skip the divide, report zero

  // operand side holds valid and data until ready
  modport prep (
    output valid,
    output num,
    output den,
    output bad,
    input  ready
  );

  // divider side
  modport div (
    input  valid,
    input  num,
    input  den,
    input  bad,
    output ready
  );

endinterface

// File: hw/operand_prep.sv
`timescale 1ns/1ps

module operand_prep #(
  parameter int TURNS_NUM = 11,             // turns ratio numerator
  parameter int TURNS_DEN = 2,              // turns ratio denominator
  parameter int FS_GAIN   = 4               // fs term gain, out code units
) (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               start,
  input  dab_pkg::in_code_t  vdc1,
  input  dab_pkg::in_code_t  vdc2,
  input  dab_pkg::fs_code_t  fs,
  output logic               busy,
  div_req_if.prep            req,
  input  logic               done
);
  import dab_pkg::*;
  import arith_pkg::*;

  // tau2 = 255*vdc1/(5.5*vdc2) - k*fs/(5.5*vdc2)
  //      = (255*TURNS_DEN*vdc1 - FS_GAIN*fs) / (TURNS_NUM*vdc2)
  localparam int V1_GAIN = FULL_SCALE * TURNS_DEN;

  logic      accept;                        // start taken this cycle
  in_code_t  vdc1_q;                        // latched inputs
  in_code_t  vdc2_q;
  fs_code_t  fs_q;
  num_t      v1_term;
  num_t      fs_term;

  assign accept = start && !busy;           // start while busy is dropped

  ////////////////////////////////////////
  // handshake control
  ////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      busy      <= 1'b0;
      req.valid <= 1'b0;
    end
    else
    begin
      if (accept)
        busy <= 1'b1;                       // covers the whole flight
      else if (done)
        busy <= 1'b0;                       // result is out
      if (accept)
        req.valid <= 1'b1;                  // operands ready next cycle
      else if (req.valid && req.ready)
        req.valid <= 1'b0;                  // taken by the divider
    end
  end

  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      vdc1_q <= vdc1;
      vdc2_q <= vdc2;
      fs_q   <= fs;
    end
  end

  ////////////////////////////////////////
  // operand forming, all held with the latches
  ////////////////////////////////////////

  assign v1_term = num_t'(V1_GAIN) * num_t'(vdc1_q);    // pi * vdc1 side
  assign fs_term = num_t'(FS_GAIN) * num_t'(fs_q);      // frequency term
  assign req.num = v1_term - fs_term;
  assign req.den = den_t'(TURNS_NUM) * den_t'(vdc2_q);  // vdc2 referred to side 1
  // no divide on dead secondary or negative tau2
  assign req.bad = (vdc2_q <= in_code_t'(0)) || req.num[NUM_W];

  // a result only answers the request in flight, after the divider took it
  a_done_in_flight: assert property (@(posedge clk) disable iff (!rst_n)
    done |-> (busy && !req.valid));

endmodule

// File: hw/restoring_divider.sv
`timescale 1ns/1ps

module restoring_divider (
  input  logic                clk,
  input  logic                rst_n,
  div_req_if.div              req,
  output logic                rsp_valid,
  output arith_pkg::quo_rsp_t rsp
);
  import arith_pkg::*;

  localparam int DEN_W = $bits(den_t);
  localparam int CNT_W = $clog2(NUM_W + 1);

  logic              running;               // division in progress
  logic [CNT_W-1:0]  cnt;                   // steps done so far
  logic [DEN_W-1:0]  rem;                   // partial remainder
  quo_t              quo_sh;                // dividend out, quotient in
  den_t              den_q;                 // held divisor
  logic              bad_q;                 // pass-through flag
  logic              take;                  // transfer on this edge
  quo_t              num_mag;               // |num|
  logic [DEN_W:0]    trial;                 // remainder with next bit
  logic [DEN_W+1:0]  diff;                  // trial - divisor
  logic              fits;                  // divisor goes in

  assign req.ready = !running;              // single request slot
  assign take      = req.valid && req.ready;

  // magnitude of the numerator, sign already folded into bad
  assign num_mag = req.num[NUM_W] ? quo_t'(-req.num) : quo_t'(req.num);

  ////////////////////////////////////////
  // one restoring step
  ////////////////////////////////////////

  assign trial = {rem, quo_sh[NUM_W-1]};    // shift in next dividend bit
  assign diff  = {1'b0, trial} - {2'b00, den_q};
  assign fits  = !diff[DEN_W+1];            // no borrow

  ////////////////////////////////////////
  // control, NUM_W steps then one result edge
  ////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      running   <= 1'b0;
      cnt       <= '0;
      rsp_valid <= 1'b0;
    end
    else
    begin
      rsp_valid <= 1'b0;                    // strobe, one cycle
      if (take)
      begin
        running <= 1'b1;
        cnt     <= '0;
      end
      else if (running)
      begin
        if (cnt == CNT_W'(NUM_W))
        begin
          running   <= 1'b0;                // free again
          rsp_valid <= 1'b1;                // quotient complete
        end
        else
          cnt <= cnt + 1'b1;
      end
    end
  end

  ////////////////////////////////////////
  // datapath
  ////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (take)
    begin
      rem    <= '0;
      quo_sh <= num_mag;
      den_q  <= req.den;
      bad_q  <= req.bad;                    // still walks the counter
    end
    else if (running && (cnt != CNT_W'(NUM_W)))
    begin
      rem    <= fits ? diff[DEN_W-1:0] : trial[DEN_W-1:0];  // restore on miss
      quo_sh <= {quo_sh[NUM_W-2:0], fits};                  // quotient bit in
    end
    if (running && (cnt == CNT_W'(NUM_W)))
    begin
      rsp.quo <= bad_q ? '0 : quo_sh;       // zero out skipped divides
      rsp.bad <= bad_q;
    end
  end

  // prep must flag every request with a zero divisor
  a_den_nonzero: assert property (@(posedge clk) disable iff (!rst_n)
    (req.valid && req.ready && !req.bad) |-> (req.den != '0));

endmodule

// File: hw/mode_select.sv
`timescale 1ns/1ps

module mode_select (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                rsp_valid,
  input  arith_pkg::quo_rsp_t rsp,
  output logic                done,
  output dab_pkg::out_code_t  tau1,
  output dab_pkg::out_code_t  tau2,
  output dab_pkg::out_code_t  phi,
  output dab_pkg::mode_e      mode
);
  import dab_pkg::*;
  import arith_pkg::*;

  logic      in_range;                      // tau2 not past pi
  logic      branch_ok;                     // single-side branch usable
  out_code_t tau2_new;
  out_code_t phi_new;

  ////////////////////////////////////////
  // branch check
  ////////////////////////////////////////

  assign in_range  = (rsp.quo <= quo_t'(FULL_SCALE));
  assign branch_ok = !rsp.bad && in_range;

  // quotient fits 8 bits once in range, sign bit stays 0
  assign tau2_new = out_code_t'(rsp.quo);
  assign phi_new  = out_code_t'(rsp.quo >> 1);          // phi = tau2/2, truncated

  ////////////////////////////////////////
  // output register, holds on no branch
  ////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      done <= 1'b0;
      tau1 <= '0;
      tau2 <= '0;
      phi  <= '0;
      mode <= MODE_NONE;                    // nothing computed yet
    end
    else
    begin
      done <= rsp_valid;                    // one cycle after the quotient
      if (rsp_valid)
      begin
        if (branch_ok)
        begin
          tau1 <= out_code_t'(FULL_SCALE);  // full width on side 1
          tau2 <= tau2_new;
          phi  <= phi_new;
          mode <= MODE_SINGLE;
        end
        else
        begin
          // previous angles stay on the bridge
          mode <= MODE_NONE;
        end
      end
    end
  end

  // single request in flight, so done never repeats back to back
  a_done_single: assert property (@(posedge clk) disable iff (!rst_n)
    done |=> !done);

endmodule

// File: hw/dab_modulator.sv
`timescale 1ns/1ps

module dab_modulator #(
  parameter int TURNS_NUM = 11,             // 5.5 = 11/2
  parameter int TURNS_DEN = 2,
  parameter int FS_GAIN   = 4               // fs term gain
) (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               start,
  input  dab_pkg::in_code_t  vdc1,
  input  dab_pkg::in_code_t  vdc2,
  input  dab_pkg::fs_code_t  fs,
  output logic               busy,
  output logic               done,
  output dab_pkg::out_code_t tau1,
  output dab_pkg::out_code_t tau2,
  output dab_pkg::out_code_t phi,
  output dab_pkg::mode_e     mode
);
  import arith_pkg::*;

  div_req_if req_bus ();                    // prep -> divider

  logic     rsp_valid;                      // divider -> select strobe
  quo_rsp_t rsp;

  ////////////////////////////////////////
  // operand preparation
  ////////////////////////////////////////

  operand_prep #(
    .TURNS_NUM (TURNS_NUM),
    .TURNS_DEN (TURNS_DEN),
    .FS_GAIN   (FS_GAIN)
  ) u_prep (
    .clk   (clk),
    .rst_n (rst_n),
    .start (start),
    .vdc1  (vdc1),
    .vdc2  (vdc2),
    .fs    (fs),
    .busy  (busy),
    .req   (req_bus.prep),
    .done  (done)                           // releases busy
  );

  ////////////////////////////////////////
  // divide and select
  ////////////////////////////////////////

  restoring_divider u_div (
    .clk       (clk),
    .rst_n     (rst_n),
    .req       (req_bus.div),
    .rsp_valid (rsp_valid),
    .rsp       (rsp)
  );

  mode_select u_sel (
    .clk       (clk),
    .rst_n     (rst_n),
    .rsp_valid (rsp_valid),
    .rsp       (rsp),
    .done      (done),
    .tau1      (tau1),
    .tau2      (tau2),
    .phi       (phi),
    .mode      (mode)
  );

endmodule

// File: tests/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int PERIOD_NS    = 40,          // clock period
  parameter int RESET_CYCLES = 2            // rising edges with rst_n low
) (
  output logic clk,
  output logic rst_n
);

  initial
  begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;    // free running
  end

  initial
  begin
    rst_n = 1'b0;                           // held low from time zero
    repeat (RESET_CYCLES) @(posedge clk);
    #2;
    rst_n = 1'b1;                           // released off the edge
  end

endmodule

// File: tests/tb_dab_modulator.sv
`timescale 1ns/1ps

module tb_dab_modulator;
  import dab_pkg::*;

  ////////////////////////////////////////
  // run constants
  ////////////////////////////////////////

  localparam int CLK_PERIOD  = 40;
  localparam int DRIVE_DLY   = 2;           // after the rising edge
  localparam int LATENCY     = 27;          // accepting edge to done
  localparam int DONE_LIMIT  = 60;          // stop waiting for done here
  localparam int N_DIR       = 12;          // directed rows
  localparam int N_RAND      = 40;          // random rows
  localparam int N_ROWS      = N_DIR + N_RAND;
  localparam int WDOG_CYCLES = N_ROWS * 35 + 20;

  // tau2 = (255*2*vdc1 - 4*fs) / (11*vdc2), floored
  localparam longint PI_CODE = 255;
  localparam longint RATIO_N = 11;
  localparam longint RATIO_D = 2;
  localparam longint FS_K    = 4;

  typedef struct packed {
    in_code_t  vdc1;
    in_code_t  vdc2;
    fs_code_t  fs;
    logic      restart;                     // extra start while busy
    mode_e     mode;                        // expected mode
    out_code_t tau2;                        // expected tau2, single rows only
  } row_t;

  logic      clk;
  logic      rst_n;
  logic      start;
  in_code_t  vdc1;
  in_code_t  vdc2;
  fs_code_t  fs;
  logic      busy;
  logic      done;
  out_code_t tau1;
  out_code_t tau2;
  out_code_t phi;
  mode_e     mode;

  row_t      dir_tab [N_DIR];
  integer    seed;
  int        code_errs;
  int        mode_errs;
  int        flag_errs;
  int        lat_errs;
  int        other_errs;
  out_code_t exp_tau1;                      // held expectations
  out_code_t exp_tau2;
  out_code_t exp_phi;
  mode_e     exp_mode;

  tb_clock_gen #(
    .PERIOD_NS    (CLK_PERIOD),
    .RESET_CYCLES (2)
  ) u_clk (
    .clk   (clk),
    .rst_n (rst_n)
  );

  dab_modulator uut (
    .clk   (clk),
    .rst_n (rst_n),
    .start (start),
    .vdc1  (vdc1),
    .vdc2  (vdc2),
    .fs    (fs),
    .busy  (busy),
    .done  (done),
    .tau1  (tau1),
    .tau2  (tau2),
    .phi   (phi),
    .mode  (mode)
  );

  ////////////////////////////////////////
  // compare tasks
  ////////////////////////////////////////

  task automatic check_code(input out_code_t got, input out_code_t exp, input string what);
    if (got !== exp)
    begin
      code_errs++;
      $display("CHECK FAILED at time %0t: %s got %0d expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_mode(input mode_e got, input mode_e exp, input string what);
    if (got !== exp)
    begin
      mode_errs++;
      $display("CHECK FAILED at time %0t: %s got %s expected %s",
               $time, what, got.name(), exp.name());
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp)
    begin
      flag_errs++;
      $display("CHECK FAILED at time %0t: %s got %b expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_latency(input int got, input int exp, input string what);
    if (got != exp)
    begin
      lat_errs++;
      $display("CHECK FAILED at time %0t: %s got %0d cycles expected %0d",
               $time, what, got, exp);
    end
  endtask

  ////////////////////////////////////////
  // reference model and stimulus
  ////////////////////////////////////////

  // floored tau2 and validity of the single-side branch
  function automatic void ref_model(input in_code_t v1, input in_code_t v2,
                                    input fs_code_t f, output logic ok, output longint quo);
    longint num;
    longint den;
    num = PI_CODE * RATIO_D * longint'(v1) - FS_K * longint'(f);
    den = RATIO_N * longint'(v2);
    quo = 0;
    ok  = 1'b0;
    if (v2 > 0 && num >= 0)                 // otherwise no divide at all
    begin
      quo = num / den;
      ok  = (quo <= PI_CODE);               // tau2 past pi is unusable
    end
  endfunction

  function automatic row_t random_row();
    row_t r;
    r.vdc1    = in_code_t'($random(seed) % 3000);
    r.vdc2    = in_code_t'(($random(seed) % 2000) + 1500);  // mostly positive
    r.fs      = fs_code_t'($random(seed) % 60000);
    r.restart = 1'b0;
    r.mode    = MODE_NONE;                  // unused for random rows
    r.tau2    = '0;
    return r;
  endfunction

  task automatic load_table();
    dir_tab[0]  = '{14'sd1000, 14'sd400, 19'sd2000, 1'b0, MODE_SINGLE, 9'sd114};
    dir_tab[1]  = '{14'sd2000, 14'sd1000, 19'sd0, 1'b0, MODE_SINGLE, 9'sd92};
    dir_tab[2]  = '{14'sd4000, 14'sd200, 19'sd0, 1'b0, MODE_NONE, 9'sd0};    // 927
    dir_tab[3]  = '{14'sd550, 14'sd100, 19'sd0, 1'b0, MODE_SINGLE, 9'sd255}; // edge
    dir_tab[4]  = '{14'sd552, 14'sd100, -19'sd20, 1'b0, MODE_NONE, 9'sd0};   // 256
    dir_tab[5]  = '{14'sd1000, 14'sd0, 19'sd0, 1'b0, MODE_NONE, 9'sd0};
    dir_tab[6]  = '{14'sd1000, -14'sd50, 19'sd0, 1'b0, MODE_NONE, 9'sd0};
    dir_tab[7]  = '{-14'sd100, 14'sd400, 19'sd0, 1'b0, MODE_NONE, 9'sd0};
    dir_tab[8]  = '{14'sd100, 14'sd400, 19'sd20000, 1'b0, MODE_NONE, 9'sd0}; // fs wins
    dir_tab[9]  = '{14'sd0, 14'sd400, 19'sd0, 1'b0, MODE_SINGLE, 9'sd0};
    dir_tab[10] = '{14'sd3000, 14'sd2000, -19'sd1000, 1'b0, MODE_SINGLE, 9'sd69};
    dir_tab[11] = '{14'sd1000, 14'sd400, 19'sd2000, 1'b1, MODE_SINGLE, 9'sd114};
  endtask

  // one start, then wait for done; latency -1 when it never came
  task automatic apply_row(input row_t row, output int latency);
    int cycles;
    @(posedge clk);
    #DRIVE_DLY;
    start = 1'b1;
    vdc1  = row.vdc1;
    vdc2  = row.vdc2;
    fs    = row.fs;
    @(posedge clk);                         // accepting edge
    #DRIVE_DLY;
    start = 1'b0;
    vdc1  = '0;                             // result must come from the latches
    vdc2  = '0;
    fs    = '0;
    check_flag(busy, 1'b1, "busy after accepted start");
    cycles = 0;
    while (done !== 1'b1 && cycles < DONE_LIMIT)
    begin
      @(posedge clk);
      #DRIVE_DLY;
      cycles++;
      start = 1'b0;
      if (row.restart && cycles == 4)
      begin
        start = 1'b1;                       // busy is high, to be dropped
        vdc1  = 14'sd100;
        vdc2  = 14'sd1;
      end
    end
    start = 1'b0;
    if (done === 1'b1)
      latency = cycles;
    else
      latency = -1;
  endtask

  task automatic watch_extra_done(input int n);
    int extra;
    extra = 0;
    repeat (n)
    begin
      @(posedge clk);
      #DRIVE_DLY;
      if (done === 1'b1)
        extra++;
    end
    if (extra != 0)
    begin
      other_errs++;
      $display("start during busy was not ignored, %0d extra done pulses", extra);
    end
  endtask

  ////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////

  initial
  begin
    int     lat;
    logic   ok;
    longint quo;
    row_t   row;
    start      = 1'b0;
    vdc1       = '0;
    vdc2       = '0;
    fs         = '0;
    seed       = 32'hfac7c216;
    code_errs  = 0;
    mode_errs  = 0;
    flag_errs  = 0;
    lat_errs   = 0;
    other_errs = 0;
    exp_tau1   = '0;
    exp_tau2   = '0;
    exp_phi    = '0;
    exp_mode   = MODE_NONE;
    load_table();

    wait (rst_n === 1'b1);
    @(posedge clk);
    #DRIVE_DLY;
    check_flag(busy, 1'b0, "busy after reset");
    check_flag(done, 1'b0, "done after reset");
    check_code(tau1, '0, "tau1 after reset");
    check_code(tau2, '0, "tau2 after reset");
    check_code(phi, '0, "phi after reset");
    check_mode(mode, MODE_NONE, "mode after reset");

    for (int i = 0; i < N_ROWS; i++)
    begin
      if (i < N_DIR)
        row = dir_tab[i];
      else
        row = random_row();
      ref_model(row.vdc1, row.vdc2, row.fs, ok, quo);
      if (i < N_DIR)
      begin
        if ((ok != (row.mode == MODE_SINGLE)) || (ok && out_code_t'(quo) != row.tau2))
        begin
          other_errs++;
          $display("table row %0d does not agree with the reference model", i);
        end
      end
      apply_row(row, lat);
      if (ok)
      begin
        exp_tau1 = out_code_t'(PI_CODE);    // side 1 full width
        exp_tau2 = out_code_t'(quo);
        exp_phi  = out_code_t'(quo / 2);
        exp_mode = MODE_SINGLE;
      end
      else
        exp_mode = MODE_NONE;               // angles stay as they were
      if (lat < 0)
      begin
        other_errs++;
        $display("row %0d: done never came within %0d cycles of start", i, DONE_LIMIT);
      end
      else
      begin
        check_latency(lat, LATENCY, $sformatf("row %0d latency", i));
        check_code(tau1, exp_tau1, $sformatf("row %0d tau1", i));
        check_code(tau2, exp_tau2, $sformatf("row %0d tau2", i));
        check_code(phi, exp_phi, $sformatf("row %0d phi", i));
        check_mode(mode, exp_mode, $sformatf("row %0d mode", i));
      end
      if (row.restart)
        watch_extra_done(35);
    end

    $display("errors: code %0d, mode %0d, flag %0d, latency %0d, other %0d",
             code_errs, mode_errs, flag_errs, lat_errs, other_errs);
    if (code_errs + mode_errs + flag_errs + lat_errs + other_errs == 0)
      $display("TEST PASSED");
    else
      $display("TEST FAILED");
    $finish;
  end

  // bound on the whole run
  initial
  begin
    #(WDOG_CYCLES * CLK_PERIOD);
    $display("watchdog expired after %0d clock periods, run did not finish", WDOG_CYCLES);
    $display("TEST FAILED");
    $finish;
  end

endmodule

// File: build.f
hw/dab_pkg.sv
hw/arith_pkg.sv
hw/div_req_if.sv
hw/operand_prep.sv
hw/restoring_divider.sv
hw/mode_select.sv
hw/dab_modulator.sv
tests/tb_clock_gen.sv
tests/tb_dab_modulator.sv

// File: run.sh
#!/usr/bin/env bash
# compile and run the dab modulator testbench with verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
  -f build.f \
  --top-module tb_dab_modulator \
  -o sim_dab

./obj_dir/sim_dab | tee sim.log

if grep -q "TEST PASSED" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed, see sim.log"
  exit 1
fi
